/* compile.f */
+incdir+include
src/alert_pkg.sv
src/diff_decode.sv
src/alert_sender.sv
src/alert_receiver.sv
src/link_integrity.sv
src/alert_link_top.sv
verification/alert_link_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the alert link simulation with Verilator

set -u

cd "$(dirname "$0")" || exit 1

obj_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f compile.f \
  --top-module alert_link_tb \
  --Mdir "$obj_dir" \
  -o alert_link_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

"./$obj_dir/alert_link_sim" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qF "*** TEST PASSED ***" "$log_file"; then
  exit 0
fi
exit 1

/* verification/alert_link_tb.sv */
/*
 * alert link testbench
 * loops both wire pairs back with skew and fault injection,
 * predicts alert and fault counts and compares them with the DUT
 */

`timescale 1ns/1ps
`default_nettype none

`include "alert_link_config.svh"

module alert_link_tb
  import alert_pkg::*;
;

  // 1 + 30 + 8 + 1 handshakes, each given 40 cycles
  localparam int num_handshakes = 40;
  localparam int timeout_cycles = num_handshakes * 40 + 1000;
  localparam int hs_limit       = 80;
  localparam int settle_cycles  = 8;

  logic       clk_i = 1'b0;
  logic       rst_ni;
  logic       trig_req_i, trig_ack_o, alert_o;
  logic       integ_clr_i, integ_fail_o;
  fault_cnt_t fault_cnt_o;
  diff_pair_t alert_tx, alert_rx, ack_tx, ack_rx;

  // loopback controls, per pair
  logic       alert_skew, ack_skew;
  logic       alert_force, ack_force;
  diff_pair_t alert_force_val, ack_force_val;
  logic       alert_n_dly_q, ack_n_dly_q;

  logic [31:0] rng = 32'h79ea_78e6;
  int          cycle_cnt = 0;
  int          alerts_seen = 0;
  int          error_cnt = 0;
  int          check_cnt = 0;
  int          exp_alerts = 0;
  fault_cnt_t  exp_faults = '0;
  logic        exp_fail = 1'b0;

  always #2 clk_i = ~clk_i;

  alert_link_top uut (
    .clk_i,
    .rst_ni,
    .trig_req_i,
    .trig_ack_o,
    .alert_o,
    .alert_tx_o  (alert_tx),
    .alert_rx_i  (alert_rx),
    .ack_tx_o    (ack_tx),
    .ack_rx_i    (ack_rx),
    .integ_clr_i,
    .integ_fail_o,
    .fault_cnt_o
  );

  ////////////////////
  // loopback wiring
  ////////////////////
  // one cycle late copy of each n wire for skew
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      alert_n_dly_q <= 1'b1;
      ack_n_dly_q   <= 1'b1;
    end else begin
      alert_n_dly_q <= alert_tx.n;
      ack_n_dly_q   <= ack_tx.n;
    end
  end

  // a forced pair overrides both wires
  assign alert_rx = alert_force ? alert_force_val :
                    diff_pair_t'({alert_tx.p, alert_skew ? alert_n_dly_q : alert_tx.n});
  assign ack_rx   = ack_force ? ack_force_val :
                    diff_pair_t'({ack_tx.p, ack_skew ? ack_n_dly_q : ack_tx.n});

  ////////////////////
  // reference model
  ////////////////////
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic int next_rand(input int unsigned span);
    rng = xorshift32(rng);
    return int'(rng % span);
  endfunction

  function automatic logic [31:0] fault_window(input int start, input int len);
    return ((32'h1 << len) - 32'h1) << start;
  endfunction

  // each rising edge of the ORed fault maps is one episode, count saturates
  function automatic fault_cnt_t predict_fault_cnt(input fault_cnt_t prev,
                                                   input logic [31:0] alert_map,
                                                   input logic [31:0] ack_map);
    logic [31:0] merged;
    logic        last;
    int unsigned cnt;
    int unsigned cnt_max;
    merged  = alert_map | ack_map;
    last    = 1'b0;
    cnt     = prev;
    cnt_max = (1 << `FAULT_CNT_W) - 1;
    for (int i = 0; i < 32; i++) begin
      if (merged[i] && !last && cnt < cnt_max) begin
        cnt++;
      end
      last = merged[i];
    end
    return fault_cnt_t'(cnt);
  endfunction

  ////////////////////
  // monitors and checks
  ////////////////////
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (rst_ni && alert_o) begin
      alerts_seen <= alerts_seen + 1;
    end
    // the receiver must not see a request through a broken pair
    assert (!(alert_force && alert_o)) else begin
      error_cnt++;
      $display("** Error at %0t: alert_o = 1, expected 0 during alert pair fault", $time);
    end
    if (cycle_cnt >= timeout_cycles) begin
      $display("run stopped after %0d cycles, the link did not finish in time", cycle_cnt);
      $display("checks: %0d, errors: %0d", check_cnt, error_cnt);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  task automatic check_value(input string name, input int got, input int exp);
    check_cnt++;
    assert (got == exp) else begin
      error_cnt++;
      $display("** Error at %0t: %s = %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic compare_state();
    check_value("alert_o pulses", alerts_seen, exp_alerts);
    check_value("fault_cnt_o", int'(fault_cnt_o), int'(exp_faults));
    check_value("integ_fail_o", int'(integ_fail_o), int'(exp_fail));
    check_value("trig_ack_o", int'(trig_ack_o), 0);
  endtask

  ////////////////////
  // stimulus tasks
  ////////////////////
  // wait for trig_ack_o high, drop the request, wait for it low
  task automatic complete_handshake();
    int waited;
    waited = 0;
    while (!trig_ack_o && waited < hs_limit) begin
      @(negedge clk_i);
      waited++;
    end
    assert (trig_ack_o) else begin
      error_cnt++;
      $display("%0t: trig_ack_o did not rise within %0d cycles", $time, hs_limit);
    end
    trig_req_i = 1'b0;
    waited = 0;
    while (trig_ack_o && waited < hs_limit) begin
      @(negedge clk_i);
      waited++;
    end
    assert (!trig_ack_o) else begin
      error_cnt++;
      $display("%0t: trig_ack_o stayed high after trig_req_i dropped", $time);
    end
    exp_alerts++;
  endtask

  task automatic run_handshake();
    trig_req_i = 1'b1;
    @(negedge clk_i);
    complete_handshake();
  endtask

  task automatic inject_faults(input logic [31:0] alert_map, input logic [31:0] ack_map);
    alert_force_val = (next_rand(2) == 0) ? diff_pair_t'(2'b00) : diff_pair_t'(2'b11);
    ack_force_val   = (next_rand(2) == 0) ? diff_pair_t'(2'b00) : diff_pair_t'(2'b11);
    for (int i = 0; i < 32; i++) begin
      alert_force = alert_map[i];
      ack_force   = ack_map[i];
      @(negedge clk_i);
    end
    alert_force = 1'b0;
    ack_force   = 1'b0;
    repeat (settle_cycles) @(negedge clk_i);
    exp_faults = predict_fault_cnt(exp_faults, alert_map, ack_map);
    exp_fail   = exp_fail | ((alert_map | ack_map) != '0);
  endtask

  // single, overlapping or separated faults on one or both pairs
  task automatic fault_round();
    int          mode, len_a, len_b, start_b;
    logic [31:0] amap, bmap;
    mode  = next_rand(4);
    len_a = 4 + next_rand(6);
    len_b = 4 + next_rand(6);
    amap  = '0;
    bmap  = '0;
    case (mode)
      0: amap = fault_window(0, len_a);
      1: bmap = fault_window(0, len_b);
      2: begin
        // overlap of at least 3 cycles
        start_b = 1 + next_rand(len_a - 3);
        amap    = fault_window(0, len_a);
        bmap    = fault_window(start_b, len_b);
      end
      default: begin
        start_b = len_a + 4 + next_rand(5);
        amap    = fault_window(0, len_a);
        bmap    = fault_window(start_b, len_b);
        if (next_rand(2) == 0) begin
          amap = amap | bmap;
          bmap = '0;
        end
      end
    endcase
    inject_faults(amap, bmap);
    compare_state();
  endtask

  ////////////////////
  // test sequence
  ////////////////////
  initial begin
    logic [31:0] map;
    rst_ni          = 1'b0;
    trig_req_i      = 1'b0;
    integ_clr_i     = 1'b0;
    alert_skew      = 1'b0;
    ack_skew        = 1'b0;
    alert_force     = 1'b0;
    ack_force       = 1'b0;
    alert_force_val = diff_pair_t'(2'b01);
    ack_force_val   = diff_pair_t'(2'b01);
    repeat (16) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    compare_state();
    check_value("alert_tx_o", int'(alert_tx), 1);
    check_value("ack_tx_o", int'(ack_tx), 1);

    // one handshake
    run_handshake();
    repeat (4) @(negedge clk_i);
    compare_state();

    // back to back triggers with random gaps
    for (int i = 0; i < 30; i++) begin
      repeat (next_rand(16)) @(negedge clk_i);
      run_handshake();
    end
    repeat (4) @(negedge clk_i);
    compare_state();

    // n wire one cycle late on alert, ack or both pairs
    for (int i = 0; i < 8; i++) begin
      map        = 32'(1 + next_rand(3));
      alert_skew = map[0];
      ack_skew   = map[1];
      @(negedge clk_i);
      run_handshake();
    end
    alert_skew = 1'b0;
    ack_skew   = 1'b0;
    repeat (4) @(negedge clk_i);
    compare_state();

    // alert pair broken while a trigger is pending
    alert_force_val = diff_pair_t'(2'b11);
    for (int i = 0; i < 10; i++) begin
      alert_force = 1'b1;
      if (i == 2) begin
        trig_req_i = 1'b1;
      end
      @(negedge clk_i);
    end
    alert_force = 1'b0;
    check_value("alert_o pulses", alerts_seen, exp_alerts);
    check_value("integ_fail_o", int'(integ_fail_o), 1);
    exp_faults = predict_fault_cnt(exp_faults, fault_window(0, 10), '0);
    exp_fail   = 1'b1;
    complete_handshake();
    repeat (4) @(negedge clk_i);
    compare_state();

    // episodes from the OR of both pairs
    for (int i = 0; i < 6; i++) begin
      fault_round();
    end

    // clear, then count again from zero
    integ_clr_i = 1'b1;
    @(negedge clk_i);
    integ_clr_i = 1'b0;
    exp_faults  = '0;
    exp_fail    = 1'b0;
    compare_state();
    fault_round();

    $display("checks: %0d, errors: %0d", check_cnt, error_cnt);
    if (error_cnt == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* src/alert_link_top.sv */
/*
 * alert link top
 * sender and receiver side by side plus the integrity monitor,
 * wire pairs leave and re-enter here
 */

`timescale 1ns/1ps
`default_nettype none

`include "alert_link_config.svh"

module alert_link_top
  import alert_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  // local trigger handshake
  input  logic       trig_req_i,
  output logic       trig_ack_o,
  // alert event at the receiving end
  output logic       alert_o,
  // wire pairs, looped back outside
  output diff_pair_t alert_tx_o,
  input  diff_pair_t alert_rx_i,
  output diff_pair_t ack_tx_o,
  input  diff_pair_t ack_rx_i,
  // integrity status
  input  logic       integ_clr_i,
  output logic       integ_fail_o,
  output fault_cnt_t fault_cnt_o
);

  logic ack_sigint, alert_sigint;

  alert_sender #(
    .async_on(`ALERT_ASYNC)
  ) u_sender (
    .clk_i,
    .rst_ni,
    .trig_req_i,
    .trig_ack_o,
    .alert_tx_o,
    .ack_rx_i,
    .ack_sigint_o(ack_sigint)
  );

  alert_receiver #(
    .async_on(`ALERT_ASYNC)
  ) u_receiver (
    .clk_i,
    .rst_ni,
    .alert_rx_i,
    .ack_tx_o,
    .alert_o,
    .alert_sigint_o(alert_sigint)
  );

  // merged fault flag across both pairs
  link_integrity u_integrity (
    .clk_i,
    .rst_ni,
    .alert_sigint_i(alert_sigint),
    .ack_sigint_i  (ack_sigint),
    .integ_clr_i,
    .integ_fail_o,
    .fault_cnt_o
  );

endmodule

`default_nettype wire

/* src/link_integrity.sv */
/*
 * link integrity monitor
 * merges both sides' sigint flags into a sticky fail flag
 * and a saturating count of fault episodes
 */

`timescale 1ns/1ps
`default_nettype none

module link_integrity
  import alert_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       alert_sigint_i,
  input  logic       ack_sigint_i,
  input  logic       integ_clr_i,
  output logic       integ_fail_o,
  output fault_cnt_t fault_cnt_o
);

  logic       fault, fault_q, fault_rise;
  logic       fail_q;
  fault_cnt_t cnt_q;

  // overlapping faults on the two pairs make a single episode
  assign fault      = alert_sigint_i | ack_sigint_i;
  assign fault_rise = fault & ~fault_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      fault_q <= 1'b0;
      fail_q  <= 1'b0;
      cnt_q   <= '0;
    end else begin
      fault_q <= fault;
      // clear wins over a new episode in the same cycle
      if (integ_clr_i) begin
        fail_q <= 1'b0;
        cnt_q  <= '0;
      end else if (fault_rise) begin
        fail_q <= 1'b1;
        if (!(&cnt_q)) begin
          cnt_q <= cnt_q + 1'b1;
        end
      end
    end
  end

  assign integ_fail_o = fail_q;
  assign fault_cnt_o  = cnt_q;

  cnt_monotonic_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $past(rst_ni) && !$past(integ_clr_i) |-> fault_cnt_o >= $past(fault_cnt_o));

endmodule

`default_nettype wire

/* src/alert_receiver.sv */
/*
 * alert receiver
 * decodes the alert pair, mirrors its level on the ack pair
 * and emits one alert pulse per link handshake
 */

`timescale 1ns/1ps
`default_nettype none

module alert_receiver
  import alert_pkg::*;
#(
  parameter bit async_on = 1'b0
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  diff_pair_t alert_rx_i,
  output diff_pair_t ack_tx_o,
  output logic       alert_o,
  output logic       alert_sigint_o
);

  receiver_state_e state_d, state_q;
  diff_pair_t      ack_tx_d, ack_tx_q;
  logic            alert_d, alert_q;
  diff_ev_t        alert_ev;

  // alert pair decoder
  diff_decode #(
    .async_on(async_on)
  ) u_alert_decode (
    .clk_i,
    .rst_ni,
    .pair_i  (alert_rx_i),
    .ev_o    (alert_ev),
    .sigint_o(alert_sigint_o)
  );

  // follow the decoded level, a level that comes back after a fault
  // without an edge still counts as the request
  always_comb begin : p_fsm
    state_d = state_q;
    alert_d = 1'b0;
    unique case (state_q)
      rcv_idle: begin
        if (alert_ev.level) begin
          state_d = rcv_ack_high;
          alert_d = 1'b1;
        end
      end
      rcv_ack_high: begin
        if (!alert_ev.level) begin
          state_d = rcv_idle;
        end
      end
    endcase
  end

  assign ack_tx_d = (state_d == rcv_ack_high) ? pair_active : pair_idle;

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      state_q  <= rcv_idle;
      ack_tx_q <= pair_idle;
      alert_q  <= 1'b0;
    end else begin
      state_q  <= state_d;
      ack_tx_q <= ack_tx_d;
      alert_q  <= alert_d;
    end
  end

  assign ack_tx_o = ack_tx_q;
  assign alert_o  = alert_q;

  // one pulse, never a held level
  alert_pulse_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    alert_o |=> !alert_o);

endmodule

`default_nettype wire

/* src/alert_sender.sv */
/*
 * alert sender
 * turns a local four-phase trigger into the alert pair request
 * and tracks the receiver's answer on the decoded ack pair
 */

`timescale 1ns/1ps
`default_nettype none

module alert_sender
  import alert_pkg::*;
#(
  parameter bit async_on = 1'b0
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       trig_req_i,
  output logic       trig_ack_o,
  output diff_pair_t alert_tx_o,
  input  diff_pair_t ack_rx_i,
  output logic       ack_sigint_o
);

  sender_state_e state_d, state_q;
  diff_pair_t    alert_tx_d, alert_tx_q;
  logic          trig_ack_d, trig_ack_q;
  diff_ev_t      ack_ev;

  // ack pair decoder
  diff_decode #(
    .async_on(async_on)
  ) u_ack_decode (
    .clk_i,
    .rst_ni,
    .pair_i  (ack_rx_i),
    .ev_o    (ack_ev),
    .sigint_o(ack_sigint_o)
  );

  // handshake phases, driven by decoded ack level so a fault just stalls
  always_comb begin : p_fsm
    state_d = state_q;
    unique case (state_q)
      snd_idle: begin
        if (trig_req_i) begin
          state_d = snd_req_high;
        end
      end
      // alert pair raised, wait for the ack
      snd_req_high: begin
        if (ack_ev.level) begin
          state_d = snd_wait_ack_low;
        end
      end
      // alert pair back to idle, wait for the ack to drop
      snd_wait_ack_low: begin
        if (!ack_ev.level) begin
          state_d = snd_done;
        end
      end
      // link done, hold trig_ack until the trigger drops
      snd_done: begin
        if (!trig_req_i) begin
          state_d = snd_idle;
        end
      end
      default: begin
        state_d = snd_idle;
      end
    endcase
  end

  // outputs registered alongside the state
  assign alert_tx_d = (state_d == snd_req_high) ? pair_active : pair_idle;
  assign trig_ack_d = (state_d == snd_done);

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      state_q    <= snd_idle;
      alert_tx_q <= pair_idle;
      trig_ack_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      alert_tx_q <= alert_tx_d;
      trig_ack_q <= trig_ack_d;
    end
  end

  assign alert_tx_o = alert_tx_q;
  assign trig_ack_o = trig_ack_q;

  // the sender never puts a broken encoding on the wires
  alert_tx_diff_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    alert_tx_o.p != alert_tx_o.n);

  trig_ack_idle_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q == snd_idle) |-> !trig_ack_o);

endmodule

`default_nettype wire

/* src/diff_decode.sv */
/*
 * differential pair decoder
 * recovers level and edges from a p/n pair, accepts one cycle of skew
 * between the wires in async mode and flags signal-integrity faults
 */

`timescale 1ns/1ps
`default_nettype none

module diff_decode
  import alert_pkg::*;
#(
  // adds two synchronizer flops and the skew matcher
  parameter bit async_on = 1'b0
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  diff_pair_t pair_i,
  output diff_ev_t   ev_o,
  output logic       sigint_o
);

  if (async_on) begin : gen_async

    decode_state_e state_d, state_q;
    // two sync stages, then one stage for edge detection
    diff_pair_t    sync1_q, sync2_q, pair_q;
    logic          p_edge, n_edge, check_ok;
    logic          level_d, level_q;
    logic          rise, fall, sigint;

    ////////////////////
    // synchronizers
    ////////////////////
    always_ff @(posedge clk_i or negedge rst_ni) begin : p_sync
      if (!rst_ni) begin
        sync1_q <= pair_idle;
        sync2_q <= pair_idle;
        pair_q  <= pair_idle;
        state_q <= is_std;
        level_q <= 1'b0;
      end else begin
        sync1_q <= pair_i;
        sync2_q <= sync1_q;
        pair_q  <= sync2_q;
        state_q <= state_d;
        level_q <= level_d;
      end
    end

    // wire transitions seen at the synchronizer output
    assign p_edge   = pair_q.p ^ sync2_q.p;
    assign n_edge   = pair_q.n ^ sync2_q.n;
    // a valid pair has p and n apart
    assign check_ok = sync2_q.p ^ sync2_q.n;

    ////////////////////
    // skew matcher
    ////////////////////
    // a one-cycle mismatch is accepted only when one wire has just moved,
    // a mismatch with no wire movement or lasting two cycles is a fault
    always_comb begin : p_fsm
      state_d = state_q;
      level_d = level_q;
      rise    = 1'b0;
      fall    = 1'b0;
      sigint  = 1'b0;
      unique case (state_q)
        is_std: begin
          if (check_ok) begin
            level_d = sync2_q.p;
            // both wires moved together, clean transition
            if (p_edge && n_edge) begin
              rise = sync2_q.p;
              fall = ~sync2_q.p;
            end
          end else if (p_edge || n_edge) begin
            // first wire moved, wait one cycle for the other
            state_d = is_skewed;
          end else begin
            state_d = sig_int;
            sigint  = 1'b1;
          end
        end
        is_skewed: begin
          if (check_ok) begin
            state_d = is_std;
            level_d = sync2_q.p;
            rise    = sync2_q.p;
            fall    = ~sync2_q.p;
          end else begin
            state_d = sig_int;
            sigint  = 1'b1;
          end
        end
        sig_int: begin
          // hold the level until the pair is valid again
          if (check_ok) begin
            state_d = is_std;
          end else begin
            sigint = 1'b1;
          end
        end
        default: begin
          state_d = is_std;
        end
      endcase
    end

    assign ev_o     = '{level: level_d, rise: rise, fall: fall, evt: rise | fall};
    assign sigint_o = sigint;

  end else begin : gen_sync

    logic p_q, level_q;
    logic level, rise, fall, sigint;

    // equal wires are never a legal encoding
    assign sigint = ~(pair_i.p ^ pair_i.n);
    assign level  = sigint ? level_q : pair_i.p;
    assign rise   = ~p_q & pair_i.p & ~sigint;
    assign fall   = p_q & ~pair_i.p & ~sigint;

    // edge register and held level
    always_ff @(posedge clk_i or negedge rst_ni) begin : p_edge_reg
      if (!rst_ni) begin
        p_q     <= 1'b0;
        level_q <= 1'b0;
      end else begin
        p_q     <= pair_i.p;
        level_q <= level;
      end
    end

    assign ev_o     = '{level: level, rise: rise, fall: fall, evt: rise | fall};
    assign sigint_o = sigint;

  end

  ////////////////////
  // assertions
  ////////////////////
  // no edge leaks out while the pair is broken
  sigint_no_event_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    sigint_o |-> !(ev_o.rise || ev_o.fall || ev_o.evt));

  // level is frozen for the whole fault
  sigint_level_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    sigint_o |-> $stable(ev_o.level));

endmodule

`default_nettype wire

/* src/alert_pkg.sv */
/*
 * alert link package
 * differential pair and decoded event types, fault count type, FSM state encodings
 */

`default_nettype none

`include "alert_link_config.svh"

package alert_pkg;

  // one differential wire pair, p carries the level and n its complement
  typedef struct packed {
    logic p;
    logic n;
  } diff_pair_t;

  // decoded pair as seen by the receiving end
  // evt is rise or fall
  typedef struct packed {
    logic level;
    logic rise;
    logic fall;
    logic evt;
  } diff_ev_t;

  // saturating count of link fault episodes
  typedef logic [`FAULT_CNT_W-1:0] fault_cnt_t;

  // pair encodings driven on the wires
  parameter diff_pair_t pair_idle   = '{p: 1'b0, n: 1'b1};
  parameter diff_pair_t pair_active = '{p: 1'b1, n: 1'b0};

  // decoder pattern matcher
  typedef enum logic [1:0] {is_std, is_skewed, sig_int} decode_state_e;

  // alert sender, four phases of the link handshake
  typedef enum logic [1:0] {snd_idle, snd_req_high, snd_wait_ack_low, snd_done} sender_state_e;

  // alert receiver, ack pair follows the alert level
  typedef enum logic {rcv_idle, rcv_ack_high} receiver_state_e;

endpackage

`default_nettype wire

/* include/alert_link_config.svh */
/*
 * alert link configuration
 * synchronizer enable for the decoders and the fault counter width
 */

`ifndef ALERT_LINK_CONFIG_SVH
`define ALERT_LINK_CONFIG_SVH

// 1 puts two synchronizer flops in front of each differential decoder
`define ALERT_ASYNC 1

// width of the link fault episode counter
`define FAULT_CNT_W 8

`endif
